// File: tb.f
+incdir+.
ioCmdPkg.sv
storePacker.sv
cmdFifo.sv
responseUnpacker.sv
ioCmdController.sv
ioCmd_properties.sv
ioCmdMonitor.sv
ioCmd_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ioCmd_tb
FILELIST  ?= tb.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: ioCmd_tb.sv
// Testbench top for the IO command controller, drives seeded random traffic through all ports
`default_nettype none

`include "ioCmd_macros.svh"

module ioCmd_tb import ioCmdPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_STORES = 60;
    localparam int NUM_RESP   = 40;
    localparam int NUM_LOADS  = 40;
    // Generous per-transaction budget for random stalls, plus reset and drain
    localparam int TIMEOUT    = (NUM_STORES + NUM_RESP + NUM_LOADS + 16) * 24 + 200;

    logic                        sys_clk;
    logic                        arstN;
    logic                        CommandACK;
    logic                        CommandREQ;
    cmdOp_e                      MinorOpcodeIn;
    logic [`IOCMD_DATA_BITS-1:0] CommandAddr;
    logic [`IOCMD_DATA_BITS-1:0] CommandData;
    logic [`IOCMD_REG_BITS-1:0]  CommandDestReg;
    logic                        WritebackACK;
    logic                        WritebackREQ;
    logic [`IOCMD_REG_BITS-1:0]  WritebackDestReg;
    logic [`IOCMD_DATA_BITS-1:0] WritebackData;
    logic                        IOCmdACK;
    logic                        IOCmdREQ;
    logic [`IOCMD_REG_BITS-1:0]  IOCmdDestReg;
    logic [`IOCMD_PORT_BITS-1:0] IOCmdData;
    logic                        IORespACK;
    logic                        IORespREQ;
    respKind_e                   IORespKind;
    logic [`IOCMD_REG_BITS-1:0]  IORespDestReg;
    logic [`IOCMD_PORT_BITS-1:0] IORespData;

    logic                        modelIdle;
    integer                      seed;
    int                          cycles;
    // 0 random ready, 1 all ready, 2 writeback held off
    logic [1:0]                  readyMode;

    ioCmdController u_dut (.*);

    ioCmdMonitor u_mon (.*, .idle(modelIdle));

    bind ioCmdController ioCmdProperties u_props (.*);

    function automatic logic [31:0] nextRand();
        return $random(seed);
    endfunction

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        logic [31:0] r;
        r = nextRand();
        case (readyMode)
            2'd0: begin
                IOCmdREQ     <= r[0];
                WritebackREQ <= r[1];
            end
            2'd2: begin
                IOCmdREQ     <= 1'b1;
                WritebackREQ <= 1'b0;
            end
            default: begin
                IOCmdREQ     <= 1'b1;
                WritebackREQ <= 1'b1;
            end
        endcase
    end

    always @(posedge sys_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout, run went past %0d cycles without finishing", TIMEOUT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Hold a command until the DUT takes it
    task automatic issueCmd(input cmdOp_e op, input logic [31:0] r, input logic [31:0] d);
        CommandACK     <= 1'b1;
        MinorOpcodeIn  <= op;
        CommandAddr    <= r[15:0];
        CommandData    <= d[15:0];
        CommandDestReg <= r[19:16];
        do @(posedge sys_clk); while (!CommandREQ);
        CommandACK <= 1'b0;
    endtask

    task automatic sendResp(input respKind_e kind, input logic [31:0] r, input logic [31:0] d);
        IORespACK     <= 1'b1;
        IORespKind    <= kind;
        IORespDestReg <= r[3:0];
        IORespData    <= d;
        do @(posedge sys_clk); while (!IORespREQ);
        IORespACK <= 1'b0;
    endtask

    task automatic waitIdle();
        do @(posedge sys_clk); while (!modelIdle);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        seed           = 23;
        cycles         = 0;
        readyMode      = 2'd1;
        arstN          = 1'b0;
        CommandACK     = 1'b0;
        MinorOpcodeIn  = OP_LOAD;
        CommandAddr    = '0;
        CommandData    = '0;
        CommandDestReg = '0;
        WritebackREQ   = 1'b0;
        IOCmdREQ       = 1'b0;
        IORespACK      = 1'b0;
        IORespKind     = RESP_MEM;
        IORespDestReg  = '0;
        IORespData     = '0;
        repeat (3) @(posedge sys_clk);
        arstN <= 1'b1;
        @(posedge sys_clk);

        // Load buffer is still zero here
        issueCmd(OP_LOAD, nextRand(), 32'h0);
        readyMode <= 2'd0;

        for (int i = 0; i < NUM_STORES; i++) begin
            r = nextRand();
            issueCmd(r[20] ? OP_STORE_SEND : OP_STORE, r, nextRand());
        end
        waitIdle();

        for (int i = 0; i < NUM_RESP; i++) begin
            r = nextRand();
            sendResp(r[8] ? RESP_REG : RESP_MEM, r, nextRand());
        end
        waitIdle();

        // Refresh the buffer now and then, loads only run once it has settled
        for (int i = 0; i < NUM_LOADS; i++) begin
            if (i % 8 == 0) begin
                r = nextRand();
                sendResp(r[8] ? RESP_REG : RESP_MEM, r, nextRand());
                waitIdle();
            end
            issueCmd(OP_LOAD, nextRand(), 32'h0);
        end
        waitIdle();

        // Fill the response queue with stuck register responses
        readyMode <= 2'd2;
        repeat (2) @(posedge sys_clk);
        for (int i = 0; i < `IOCMD_FIFO_DEPTH; i++) begin
            sendResp(RESP_REG, nextRand(), nextRand());
        end
        repeat (4) @(posedge sys_clk);
        readyMode <= 2'd1;
        // Load waits behind the queued register responses
        issueCmd(OP_LOAD, nextRand(), 32'h0);
        waitIdle();

        u_mon.printSummary();
        if (u_mon.errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ioCmdMonitor.sv
// Reference model and checker for the IO command controller, compares every DUT port each cycle
`default_nettype none

`include "ioCmd_macros.svh"

module ioCmdMonitor import ioCmdPkg::*; (
    input  wire logic                        sys_clk,
    input  wire logic                        arstN,
    input  wire logic                        CommandACK,
    input  wire logic                        CommandREQ,
    input  wire cmdOp_e                      MinorOpcodeIn,
    input  wire logic [`IOCMD_DATA_BITS-1:0] CommandAddr,
    input  wire logic [`IOCMD_DATA_BITS-1:0] CommandData,
    input  wire logic [`IOCMD_REG_BITS-1:0]  CommandDestReg,
    input  wire logic                        WritebackACK,
    input  wire logic                        WritebackREQ,
    input  wire logic [`IOCMD_REG_BITS-1:0]  WritebackDestReg,
    input  wire logic [`IOCMD_DATA_BITS-1:0] WritebackData,
    input  wire logic                        IOCmdACK,
    input  wire logic                        IOCmdREQ,
    input  wire logic [`IOCMD_REG_BITS-1:0]  IOCmdDestReg,
    input  wire logic [`IOCMD_PORT_BITS-1:0] IOCmdData,
    input  wire logic                        IORespACK,
    input  wire logic                        IORespREQ,
    input  wire respKind_e                   IORespKind,
    input  wire logic [`IOCMD_REG_BITS-1:0]  IORespDestReg,
    input  wire logic [`IOCMD_PORT_BITS-1:0] IORespData,
    output logic                             idle
);
    timeunit 1ns;
    timeprecision 1ps;

    int          errorCount = 0;
    int          checkCount = 0;
    logic [31:0] stageModel;
    logic [31:0] bufModel;
    // Entries are {dest, word} and {kind, dest, word}
    logic [35:0] cmdExp[$];
    logic [36:0] respExp[$];

    task automatic checkVal(input string name, input logic [35:0] got, input logic [35:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    always @(posedge sys_clk) begin : checkEdge
        logic [36:0] head;
        logic [31:0] merged;
        logic        regPend;
        logic        respPop;
        logic        loadOffer;
        logic        cmdFull;
        if (!arstN) begin
            checkVal("IOCmdACK", 36'(IOCmdACK), 36'(0));
            checkVal("WritebackACK", 36'(WritebackACK), 36'(0));
            stageModel = '0;
            bufModel   = '0;
            cmdExp.delete();
            respExp.delete();
            idle <= 1'b1;
        end else begin
            head      = (respExp.size() > 0) ? respExp[0] : '0;
            regPend   = respExp.size() > 0 && head[36];
            respPop   = respExp.size() > 0 && (!head[36] || WritebackREQ);
            loadOffer = CommandACK && MinorOpcodeIn == OP_LOAD && !regPend;
            cmdFull   = cmdExp.size() >= `IOCMD_FIFO_DEPTH && !IOCmdREQ;
            checkVal("WritebackACK", 36'(WritebackACK), 36'(regPend || loadOffer));
            checkVal("IOCmdACK", 36'(IOCmdACK), 36'(cmdExp.size() != 0));
            checkVal("IORespREQ", 36'(IORespREQ),
                     36'(respExp.size() < `IOCMD_FIFO_DEPTH || respPop));

            if (IOCmdACK && IOCmdREQ && cmdExp.size() != 0) begin
                checkVal("IOCmdDestReg", 36'(IOCmdDestReg), 36'(cmdExp[0][35:32]));
                checkVal("IOCmdData", 36'(IOCmdData), 36'(cmdExp[0][31:0]));
                void'(cmdExp.pop_front());
            end

            if (regPend) begin
                if (WritebackREQ) begin
                    checkVal("WritebackDestReg", 36'(WritebackDestReg), 36'(head[35:32]));
                    checkVal("WritebackData", 36'(WritebackData), 36'(head[15:0]));
                end
                if (CommandACK && MinorOpcodeIn == OP_LOAD) begin
                    checkVal("CommandREQ", 36'(CommandREQ), 36'(0));
                end
            end else if (loadOffer) begin
                checkVal("CommandREQ", 36'(CommandREQ), 36'(WritebackREQ));
                if (WritebackREQ) begin
                    checkVal("WritebackDestReg", 36'(WritebackDestReg), 36'(CommandDestReg));
                    checkVal("WritebackData", 36'(WritebackData),
                             36'(CommandAddr[0] ? bufModel[31:16] : bufModel[15:0]));
                end
            end

            if (CommandACK && MinorOpcodeIn != OP_LOAD) begin
                checkVal("CommandREQ", 36'(CommandREQ),
                         36'(MinorOpcodeIn != OP_STORE_SEND || !cmdFull));
                if (CommandREQ) begin
                    merged = stageModel;
                    if (CommandAddr[0]) begin
                        merged[31:16] = CommandData;
                    end else begin
                        merged[15:0] = CommandData;
                    end
                    stageModel = merged;
                    if (MinorOpcodeIn == OP_STORE_SEND) begin
                        cmdExp.push_back({CommandDestReg, merged});
                    end
                end
            end

            if (respPop) begin
                bufModel = head[31:0];
                void'(respExp.pop_front());
            end
            if (IORespACK && IORespREQ) begin
                respExp.push_back({IORespKind, IORespDestReg, IORespData});
            end
            idle <= cmdExp.size() == 0 && respExp.size() == 0;
        end
    end

    task automatic printSummary();
        if (cmdExp.size() != 0 || respExp.size() != 0) begin
            errorCount++;
            $display("Traffic left undelivered at the end: %0d commands, %0d responses",
                     cmdExp.size(), respExp.size());
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    endtask

endmodule

`default_nettype wire

// File: ioCmd_properties.sv
// Concurrent assertions bound into the controller top, covering reset state and handshake hold
`default_nettype none

`include "ioCmd_macros.svh"

module ioCmdProperties (
    input wire logic                        sys_clk,
    input wire logic                        arstN,
    input wire logic                        IOCmdACK,
    input wire logic                        IOCmdREQ,
    input wire logic [`IOCMD_REG_BITS-1:0]  IOCmdDestReg,
    input wire logic [`IOCMD_PORT_BITS-1:0] IOCmdData,
    input wire logic                        WritebackACK,
    input wire logic                        WritebackREQ,
    input wire logic [`IOCMD_REG_BITS-1:0]  WritebackDestReg,
    input wire logic [`IOCMD_DATA_BITS-1:0] WritebackData
);
    timeunit 1ns;
    timeprecision 1ps;

    // Both outgoing valids stay low in reset
    resetQuiet: assert property (@(posedge sys_clk) !arstN |-> !IOCmdACK && !WritebackACK)
        else $error("valid raised during reset");

    // Offered IO command holds until taken
    cmdHold: assert property (@(posedge sys_clk) disable iff (!arstN)
        IOCmdACK && !IOCmdREQ |=> IOCmdACK && $stable(IOCmdData) && $stable(IOCmdDestReg))
        else $error("IO command dropped or changed before transfer");

    // Writeback holds until taken
    wbHold: assert property (@(posedge sys_clk) disable iff (!arstN)
        WritebackACK && !WritebackREQ |=> WritebackACK && $stable(WritebackData)
            && $stable(WritebackDestReg))
        else $error("writeback dropped or changed before transfer");

endmodule

`default_nettype wire

// File: ioCmdController.sv
// Top level of the IO command controller joining the core, writeback and IO port sides
`default_nettype none

`include "ioCmd_macros.svh"

module ioCmdController import ioCmdPkg::*; (
    input  wire logic                        sys_clk,
    input  wire logic                        arstN,

    // Core command port
    input  wire logic                        CommandACK,
    output logic                             CommandREQ,
    input  wire cmdOp_e                      MinorOpcodeIn,
    input  wire logic [`IOCMD_DATA_BITS-1:0] CommandAddr,
    input  wire logic [`IOCMD_DATA_BITS-1:0] CommandData,
    input  wire logic [`IOCMD_REG_BITS-1:0]  CommandDestReg,

    // Writeback port
    output logic                             WritebackACK,
    input  wire logic                        WritebackREQ,
    output logic [`IOCMD_REG_BITS-1:0]       WritebackDestReg,
    output logic [`IOCMD_DATA_BITS-1:0]      WritebackData,

    // IO command port
    output logic                             IOCmdACK,
    input  wire logic                        IOCmdREQ,
    output logic [`IOCMD_REG_BITS-1:0]       IOCmdDestReg,
    output logic [`IOCMD_PORT_BITS-1:0]      IOCmdData,

    // IO response port
    input  wire logic                        IORespACK,
    output logic                             IORespREQ,
    input  wire respKind_e                   IORespKind,
    input  wire logic [`IOCMD_REG_BITS-1:0]  IORespDestReg,
    input  wire logic [`IOCMD_PORT_BITS-1:0] IORespData
);

    // Command entry is {dest, word}, response entry adds the kind on top
    localparam int CMD_BITS  = `IOCMD_REG_BITS + `IOCMD_PORT_BITS;
    localparam int RESP_BITS = CMD_BITS + 1;

    logic                        storeREQ;
    logic                        loadREQ;
    logic                        queueACK;
    logic                        queueREQ;
    logic [`IOCMD_REG_BITS-1:0]  queueDestReg;
    logic [`IOCMD_PORT_BITS-1:0] queueData;

    logic                        respHeadACK;
    logic                        respHeadREQ;
    logic [RESP_BITS-1:0]        respHead;

    assign CommandREQ = isStore(MinorOpcodeIn) ? storeREQ : loadREQ;

    storePacker u_storePacker (
        .sys_clk        (sys_clk),
        .arstN          (arstN),
        .CommandACK     (CommandACK),
        .MinorOpcodeIn  (MinorOpcodeIn),
        .CommandAddr    (CommandAddr),
        .CommandData    (CommandData),
        .CommandDestReg (CommandDestReg),
        .StoreREQ       (storeREQ),
        .QueueACK       (queueACK),
        .QueueREQ       (queueREQ),
        .QueueDestReg   (queueDestReg),
        .QueueData      (queueData)
    );

    cmdFifo #(
        .WIDTH (CMD_BITS),
        .DEPTH (`IOCMD_FIFO_DEPTH)
    ) cmdQueue (
        .sys_clk (sys_clk),
        .arstN   (arstN),
        .InACK   (queueACK),
        .InREQ   (queueREQ),
        .InData  ({queueDestReg, queueData}),
        .OutACK  (IOCmdACK),
        .OutREQ  (IOCmdREQ),
        .OutData ({IOCmdDestReg, IOCmdData})
    );

    cmdFifo #(
        .WIDTH (RESP_BITS),
        .DEPTH (`IOCMD_FIFO_DEPTH)
    ) respQueue (
        .sys_clk (sys_clk),
        .arstN   (arstN),
        .InACK   (IORespACK),
        .InREQ   (IORespREQ),
        .InData  ({IORespKind, IORespDestReg, IORespData}),
        .OutACK  (respHeadACK),
        .OutREQ  (respHeadREQ),
        .OutData (respHead)
    );

    responseUnpacker u_responseUnpacker (
        .sys_clk          (sys_clk),
        .arstN            (arstN),
        .RespACK          (respHeadACK),
        .RespREQ          (respHeadREQ),
        .RespKind         (respKind_e'(respHead[RESP_BITS-1])),
        .RespDestReg      (respHead[CMD_BITS-1:`IOCMD_PORT_BITS]),
        .RespData         (respHead[`IOCMD_PORT_BITS-1:0]),
        .CommandACK       (CommandACK),
        .MinorOpcodeIn    (MinorOpcodeIn),
        .CommandAddr      (CommandAddr),
        .CommandDestReg   (CommandDestReg),
        .LoadREQ          (loadREQ),
        .WritebackACK     (WritebackACK),
        .WritebackREQ     (WritebackREQ),
        .WritebackDestReg (WritebackDestReg),
        .WritebackData    (WritebackData)
    );

endmodule

`default_nettype wire

// File: responseUnpacker.sv
// Response stage holding the load buffer and arbitrating writebacks between responses and loads
`default_nettype none

`include "ioCmd_macros.svh"

module responseUnpacker import ioCmdPkg::*; (
    input  wire logic                        sys_clk,
    input  wire logic                        arstN,

    // Response queue head
    input  wire logic                        RespACK,
    output logic                             RespREQ,
    input  wire respKind_e                   RespKind,
    input  wire logic [`IOCMD_REG_BITS-1:0]  RespDestReg,
    input  wire logic [`IOCMD_PORT_BITS-1:0] RespData,

    // Load commands from the core
    input  wire logic                        CommandACK,
    input  wire cmdOp_e                      MinorOpcodeIn,
    input  wire logic [`IOCMD_DATA_BITS-1:0] CommandAddr,
    input  wire logic [`IOCMD_REG_BITS-1:0]  CommandDestReg,
    output logic                             LoadREQ,

    // Writeback port
    output logic                             WritebackACK,
    input  wire logic                        WritebackREQ,
    output logic [`IOCMD_REG_BITS-1:0]       WritebackDestReg,
    output logic [`IOCMD_DATA_BITS-1:0]      WritebackData
);

    logic [`IOCMD_PORT_BITS-1:0]                     loadBuffer;
    logic [`IOCMD_LANES-1:0][`IOCMD_DATA_BITS-1:0]   loadLanes;
    logic [`IOCMD_LANE_BITS-1:0]                     laneSel;
    logic                                            regPending;
    logic                                            loadOffered;
    logic                                            respPop;

    // Register response at the head owns the writeback port
    assign regPending = RespACK && (RespKind == RESP_REG);

    // Memory responses drain at once, register ones wait for writeback
    assign RespREQ = (RespKind == RESP_MEM) || WritebackREQ;
    assign respPop = RespACK && RespREQ;

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            loadBuffer <= '0;
        end else if (respPop) begin
            loadBuffer <= RespData;
        end
    end

    // One core word per lane of the buffer
    for (genvar lane = 0; lane < `IOCMD_LANES; lane++) begin : genLanes
        assign loadLanes[lane] =
            loadBuffer[lane*`IOCMD_DATA_BITS +: `IOCMD_DATA_BITS];
    end

    assign laneSel = CommandAddr[`IOCMD_LANE_BITS-1:0];

    // Loads pass straight through to writeback when nothing outranks them
    assign loadOffered = CommandACK && !isStore(MinorOpcodeIn) && !regPending;
    assign LoadREQ     = WritebackREQ && !regPending;

    assign WritebackACK     = regPending || loadOffered;
    assign WritebackDestReg = regPending ? RespDestReg : CommandDestReg;
    assign WritebackData    = regPending ? RespData[`IOCMD_DATA_BITS-1:0]
                                         : loadLanes[laneSel];

endmodule

`default_nettype wire

// File: cmdFifo.sv
// Synchronous first-word-fall-through queue used for both command and response traffic
`default_nettype none

`include "ioCmd_macros.svh"

module cmdFifo #(
    parameter int WIDTH = `IOCMD_REG_BITS + `IOCMD_PORT_BITS,
    parameter int DEPTH = `IOCMD_FIFO_DEPTH
)(
    input  wire logic             sys_clk,
    input  wire logic             arstN,

    input  wire logic             InACK,
    output logic                  InREQ,
    input  wire logic [WIDTH-1:0] InData,

    output logic                  OutACK,
    input  wire logic             OutREQ,
    output logic [WIDTH-1:0]      OutData
);

    localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]      storage [DEPTH];
    logic [PTR_BITS-1:0]   wrPtr;
    logic [PTR_BITS-1:0]   rdPtr;
    logic [COUNT_BITS-1:0] count;
    logic                  push;
    logic                  pop;

    // A full queue still takes a word when the head leaves that cycle
    assign InREQ  = (count != COUNT_BITS'(DEPTH)) || OutREQ;
    assign OutACK = count != '0;
    assign OutData = storage[rdPtr];

    assign push = InACK && InREQ;
    assign pop  = OutACK && OutREQ;

    always_ff @(posedge sys_clk) begin
        if (push) begin
            storage[wrPtr] <= InData;
        end
    end

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_BITS'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_BITS'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: storePacker.sv
// Command stage that merges 16-bit stores into the 32-bit staging word and emits IO commands
`default_nettype none

`include "ioCmd_macros.svh"

module storePacker import ioCmdPkg::*; (
    input  wire logic                        sys_clk,
    input  wire logic                        arstN,

    // Core command side
    input  wire logic                        CommandACK,
    input  wire cmdOp_e                      MinorOpcodeIn,
    input  wire logic [`IOCMD_DATA_BITS-1:0] CommandAddr,
    input  wire logic [`IOCMD_DATA_BITS-1:0] CommandData,
    input  wire logic [`IOCMD_REG_BITS-1:0]  CommandDestReg,
    output logic                             StoreREQ,

    // Command queue side
    output logic                             QueueACK,
    input  wire logic                        QueueREQ,
    output logic [`IOCMD_REG_BITS-1:0]       QueueDestReg,
    output logic [`IOCMD_PORT_BITS-1:0]      QueueData
);

    logic [`IOCMD_PORT_BITS-1:0] stagingWord;
    logic [`IOCMD_PORT_BITS-1:0] mergedWord;
    logic [`IOCMD_LANE_BITS-1:0] laneSel;
    logic                        sendCmd;
    logic                        storeAccept;

    assign laneSel = CommandAddr[`IOCMD_LANE_BITS-1:0];
    assign sendCmd = isStoreSend(MinorOpcodeIn);

    // Plain stores never wait, sends wait for queue room
    assign StoreREQ    = sendCmd ? QueueREQ : 1'b1;
    assign storeAccept = CommandACK && isStore(MinorOpcodeIn) && StoreREQ;

    // Staging word with the incoming lane already applied
    always_comb begin
        mergedWord = stagingWord;
        mergedWord[laneSel*`IOCMD_DATA_BITS +: `IOCMD_DATA_BITS] = CommandData;
    end

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            stagingWord <= '0;
        end else if (storeAccept) begin
            stagingWord <= mergedWord;
        end
    end

    // Send goes out with the same edge that updates the staging word
    assign QueueACK     = CommandACK && sendCmd;
    assign QueueDestReg = CommandDestReg;
    assign QueueData    = mergedWord;

endmodule

`default_nettype wire

// File: ioCmdPkg.sv
// Shared opcode and IO response types for the IO command controller and its testbench
`default_nettype none

package ioCmdPkg;

    // Minor opcodes from the core command port
    // Bit 2 marks a store, the low bits pick the store flavor
    typedef enum logic [3:0] {
        OP_LOAD       = 4'h0,
        OP_STORE      = 4'h4,
        OP_STORE_SEND = 4'h5
    } cmdOp_e;

    // Kind of response coming back from the IO port
    typedef enum logic {
        RESP_MEM = 1'b0,
        RESP_REG = 1'b1
    } respKind_e;

    // Store class test shared by the command stage and the unpacker
    function automatic logic isStore(input cmdOp_e op);
        return op[2];
    endfunction

    function automatic logic isStoreSend(input cmdOp_e op);
        return op == OP_STORE_SEND;
    endfunction

endpackage

`default_nettype wire

// File: ioCmd_macros.svh
// Width and depth constants for the IO command controller, included by every design file
`ifndef IOCMD_MACROS_SVH
`define IOCMD_MACROS_SVH

// IO port word width
`define IOCMD_PORT_BITS 32

// Core data word width
`define IOCMD_DATA_BITS 16

// Core words per IO port word
`define IOCMD_LANES 2

// Address bits that pick a lane
`define IOCMD_LANE_BITS 1

// Destination register index width
`define IOCMD_REG_BITS 4

// Default queue depth in entries
`define IOCMD_FIFO_DEPTH 8

`endif
